//--- source/fpuPkg.sv
// FPU shared definitions
package fpuPkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////////////
   localparam int xLen       = 64;   // integer register width
   localparam int fLen       = 64;   // FP register width
   localparam int dExpBits   = 11;   // double exponent
   localparam int dManBits   = 52;   // double fraction, hidden bit excluded
   localparam int sExpBits   = 8;    // single exponent
   localparam int sManBits   = 23;   // single fraction
   localparam int regAdrBits = 5;

   ////////////////////////////////////////////////////////////////////////////
   // encodings
   ////////////////////////////////////////////////////////////////////////////
   localparam logic [6:0] opFp = 7'b1010011;   // OP-FP major opcode

   // upper five bits of funct7, the low two bits hold the format
   localparam logic [4:0] funct7SgnInj   = 5'b00100;
   localparam logic [4:0] funct7MinMax   = 5'b00101;
   localparam logic [4:0] funct7Cmp      = 5'b10100;
   localparam logic [4:0] funct7ClassMvX = 5'b11100;   // fclass, fmv.x.w/d
   localparam logic [4:0] funct7MvFromX  = 5'b11110;   // fmv.w/d.x

   typedef enum logic {fmtS = 1'b0, fmtD = 1'b1} fmtT;

   // FP result source
   typedef enum logic [1:0] {resSgnInj = 2'd0, resMinMax = 2'd1, resMvFromX = 2'd2} resSelT;

   // integer result source
   typedef enum logic [1:0] {intCmp = 2'd0, intMvToX = 2'd1, intClass = 2'd2} intSelT;

   typedef struct packed {
      logic                  fRegWrite;  // writes the FP register file in W
      logic                  intWrite;   // result goes to the integer side
      fmtT                   fmt;
      resSelT                resSel;
      intSelT                intSel;
      logic [2:0]            opSel;      // funct3
      logic [regAdrBits-1:0] rd;
   } fpuCtrlT;

   typedef struct packed {
      logic nv;   // invalid
      logic dz;
      logic of;
      logic uf;
      logic nx;
   } fflagsT;

   localparam logic [fLen-1:0] canonNaND = 64'h7FF8_0000_0000_0000;
   localparam logic [fLen-1:0] canonNaNS = 64'hFFFF_FFFF_7FC0_0000;   // boxed in ones

   // fclass bit positions
   localparam int clsNegInf  = 0;
   localparam int clsNegNorm = 1;
   localparam int clsNegSub  = 2;
   localparam int clsNegZero = 3;
   localparam int clsPosZero = 4;
   localparam int clsPosSub  = 5;
   localparam int clsPosNorm = 6;
   localparam int clsPosInf  = 7;
   localparam int clsSNaN    = 8;
   localparam int clsQNaN    = 9;

endpackage

//--- source/fpOperandIf.sv
// Unpacked operand bundle
`timescale 1ns/100ps

interface fpOperandIf;
   import fpuPkg::*;

   logic [fLen-1:0]     raw;       // operand after the boxing check
   logic                sgn;
   logic [dExpBits-1:0] exp;       // single exponent sits zero-extended here
   logic [dManBits:0]   man;       // hidden bit on top
   logic                isNaN;
   logic                isSNaN;
   logic                isZero;
   logic                isInf;
   logic                isDenorm;
   logic                isNorm;

   // driven by the unpacker
   modport unpack (
      output raw, sgn, exp, man,
      output isNaN, isSNaN, isZero, isInf, isDenorm, isNorm
   );

   // read by the execute units
   modport unit (
      input raw, sgn, exp, man,
      input isNaN, isSNaN, isZero, isInf, isDenorm, isNorm
   );

endinterface

//--- source/fpuDecode.sv
// FP instruction decoder
`timescale 1ns/100ps

module fpuDecode (
   input  logic [31:0]     instr,
   output fpuPkg::fpuCtrlT ctrl,
   output logic            illegal
);
   import fpuPkg::*;

   logic [6:0] opcode;
   logic [4:0] funct5;
   logic [2:0] funct3;
   logic [4:0] rs2;
   logic       fmtOk;   // only S and D encodings exist

   assign opcode = instr[6:0];
   assign funct5 = instr[31:27];
   assign funct3 = instr[14:12];
   assign rs2    = instr[24:20];
   assign fmtOk  = (instr[26] == 1'b0);

   always_comb begin
      ctrl       = '0;                 // bubble unless a legal encoding matches
      illegal    = 1'b1;
      ctrl.fmt   = fmtT'(instr[25]);
      ctrl.opSel = funct3;
      ctrl.rd    = instr[11:7];
      if (opcode == opFp && fmtOk) begin
         case (funct5)
            funct7SgnInj: begin
               if (funct3 <= 3'd2) begin   // fsgnj, fsgnjn, fsgnjx
                  ctrl.fRegWrite = 1'b1;
                  ctrl.resSel    = resSgnInj;
                  illegal        = 1'b0;
               end
            end
            funct7MinMax: begin
               if (funct3 <= 3'd1) begin   // fmin, fmax
                  ctrl.fRegWrite = 1'b1;
                  ctrl.resSel    = resMinMax;
                  illegal        = 1'b0;
               end
            end
            funct7Cmp: begin
               if (funct3 <= 3'd2) begin   // fle, flt, feq
                  ctrl.intWrite = 1'b1;
                  ctrl.intSel   = intCmp;
                  illegal       = 1'b0;
               end
            end
            funct7ClassMvX: begin
               if (rs2 == 5'd0 && funct3 <= 3'd1) begin
                  ctrl.intWrite = 1'b1;
                  ctrl.intSel   = funct3[0] ? intClass : intMvToX;   // 001 is fclass
                  illegal       = 1'b0;
               end
            end
            funct7MvFromX: begin
               if (rs2 == 5'd0 && funct3 == 3'd0) begin
                  ctrl.fRegWrite = 1'b1;
                  ctrl.resSel    = resMvFromX;
                  illegal        = 1'b0;
               end
            end
            default: ;                     // stays illegal
         endcase
      end
   end

endmodule

//--- source/fpRegFile.sv
// FP register file
`timescale 1ns/100ps

module fpRegFile (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic [fpuPkg::regAdrBits-1:0] rAdr1,
   input  logic [fpuPkg::regAdrBits-1:0] rAdr2,
   output logic [fpuPkg::fLen-1:0]       rData1,
   output logic [fpuPkg::fLen-1:0]       rData2,
   input  logic                          wEn,
   input  logic [fpuPkg::regAdrBits-1:0] wAdr,
   input  logic [fpuPkg::fLen-1:0]       wData
);
   import fpuPkg::*;

   localparam int numRegs = 2 ** regAdrBits;

   logic [fLen-1:0] regs [numRegs];

   // f0 is an ordinary register here, unlike x0
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wEn) begin
         regs[wAdr] <= wData;
      end
   end

   // write-through, so a D read of the W destination sees the new value
   always_comb begin
      rData1 = regs[rAdr1];
      rData2 = regs[rAdr2];
      if (wEn && wAdr == rAdr1) begin
         rData1 = wData;
      end
      if (wEn && wAdr == rAdr2) begin
         rData2 = wData;
      end
   end

endmodule

//--- source/fpUnpack.sv
// Operand unpack and classify
`timescale 1ns/100ps

module fpUnpack (
   input  logic [fpuPkg::fLen-1:0] value,
   input  fpuPkg::fmtT             fmt,
   fpOperandIf.unpack              op
);
   import fpuPkg::*;

   logic                boxOk;     // upper half all ones
   logic [fLen-1:0]     val;       // value, or canonical NaN when badly boxed
   logic                sgn;
   logic [dExpBits-1:0] expW;      // exponent in the double field
   logic [dManBits-1:0] fracW;     // fraction, left aligned
   logic                expMax;
   logic                expZero;
   logic                fracZero;

   assign boxOk = &value[fLen-1:32];

   always_comb begin
      if (fmt == fmtD) begin
         val     = value;
         sgn     = value[63];
         expW    = value[62:52];
         fracW   = value[dManBits-1:0];
         expMax  = &value[62:52];
         expZero = ~|value[62:52];
      end else begin
         val     = boxOk ? value : canonNaNS;
         sgn     = val[31];
         expW    = {{(dExpBits-sExpBits){1'b0}}, val[30:23]};   // keeps ordering intact
         fracW   = {val[sManBits-1:0], {(dManBits-sManBits){1'b0}}};
         expMax  = &val[30:23];                                   // tests of the active format
         expZero = ~|val[30:23];
      end
   end

   assign fracZero = ~|fracW;

   ////////////////////////////////////////////////////////////////////////////
   // fields and class
   ////////////////////////////////////////////////////////////////////////////
   assign op.raw      = val;
   assign op.sgn      = sgn;
   assign op.exp      = expW;
   assign op.man      = {~expZero, fracW};                 // hidden bit clear for denormals
   assign op.isNaN    = expMax & ~fracZero;
   assign op.isSNaN   = expMax & ~fracZero & ~fracW[dManBits-1];   // quiet bit is the msb
   assign op.isInf    = expMax & fracZero;
   assign op.isZero   = expZero & fracZero;
   assign op.isDenorm = expZero & ~fracZero;
   assign op.isNorm   = ~expMax & ~expZero;

endmodule

//--- source/fpCompare.sv
// Compare and min/max unit
`timescale 1ns/100ps

module fpCompare (
   input  fpuPkg::fmtT             fmt,
   input  logic [2:0]              opSel,   // bit 2 marks min/max
   fpOperandIf.unit                opX,
   fpOperandIf.unit                opY,
   output logic [fpuPkg::xLen-1:0] cmpRes,
   output logic [fpuPkg::fLen-1:0] minMaxRes,
   output logic                    invalid
);
   import fpuPkg::*;

   logic [dExpBits+dManBits-1:0] magX, magY;   // exponent and fraction, no sign
   logic anyNaN, anySNaN, bothZero;
   logic ordLt;                                // total order, -0 below +0
   logic eqRes, ltRes, leRes, cmpBit;
   logic pickX;

   assign magX     = {opX.exp, opX.man[dManBits-1:0]};
   assign magY     = {opY.exp, opY.man[dManBits-1:0]};
   assign anyNaN   = opX.isNaN | opY.isNaN;
   assign anySNaN  = opX.isSNaN | opY.isSNaN;
   assign bothZero = opX.isZero & opY.isZero;

   // sign first, then magnitude, reversed for two negatives
   assign ordLt = (opX.sgn != opY.sgn) ? opX.sgn :
                  (opX.sgn ? (magY < magX) : (magX < magY));

   // IEEE compares treat the two zeros as equal
   assign eqRes = ~anyNaN & (((opX.sgn == opY.sgn) & (magX == magY)) | bothZero);
   assign ltRes = ~anyNaN & ordLt & ~bothZero;
   assign leRes = ltRes | eqRes;

   always_comb begin
      case (opSel[1:0])
         2'b00:   cmpBit = leRes;
         2'b01:   cmpBit = ltRes;
         2'b10:   cmpBit = eqRes;
         default: cmpBit = 1'b0;
      endcase
   end
   assign cmpRes = {{(xLen-1){1'b0}}, cmpBit};

   ////////////////////////////////////////////////////////////////////////////
   // min/max
   ////////////////////////////////////////////////////////////////////////////
   assign pickX = opSel[0] ? ~ordLt : ordLt;   // funct3 001 is max

   always_comb begin
      if (opX.isNaN && opY.isNaN) begin
         minMaxRes = (fmt == fmtD) ? canonNaND : canonNaNS;
      end else if (opX.isNaN) begin
         minMaxRes = opY.raw;                  // the non-NaN one wins
      end else if (opY.isNaN) begin
         minMaxRes = opX.raw;
      end else begin
         minMaxRes = pickX ? opX.raw : opY.raw;
      end
   end

   // feq and min/max only complain about signaling NaNs
   assign invalid = (opSel[2] || opSel[1:0] == 2'b10) ? anySNaN : anyNaN;

endmodule

//--- source/fpSignClass.sv
// Sign injection and classify
`timescale 1ns/100ps

module fpSignClass (
   input  fpuPkg::fmtT             fmt,
   input  logic [2:0]              opSel,
   fpOperandIf.unit                opX,
   fpOperandIf.unit                opY,
   output logic [fpuPkg::fLen-1:0] sgnRes,
   output logic [fpuPkg::xLen-1:0] classRes
);
   import fpuPkg::*;

   logic       newSgn;
   logic [9:0] cls;   // fclass one-hot

   always_comb begin
      case (opSel[1:0])
         2'b00:   newSgn = opY.sgn;               // fsgnj
         2'b01:   newSgn = ~opY.sgn;              // fsgnjn
         2'b10:   newSgn = opX.sgn ^ opY.sgn;     // fsgnjx
         default: newSgn = opY.sgn;
      endcase
   end

   // magnitude always from X, single re-boxed in ones
   assign sgnRes = (fmt == fmtD) ? {newSgn, opX.raw[62:0]} :
                                   {32'hFFFF_FFFF, newSgn, opX.raw[30:0]};

   ////////////////////////////////////////////////////////////////////////////
   // classify X
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      cls = '0;
      if (opX.isSNaN) begin
         cls[clsSNaN] = 1'b1;
      end else if (opX.isNaN) begin
         cls[clsQNaN] = 1'b1;
      end else if (opX.isInf) begin
         cls[opX.sgn ? clsNegInf : clsPosInf] = 1'b1;
      end else if (opX.isZero) begin
         cls[opX.sgn ? clsNegZero : clsPosZero] = 1'b1;
      end else if (opX.isDenorm) begin
         cls[opX.sgn ? clsNegSub : clsPosSub] = 1'b1;
      end else if (opX.isNorm) begin
         cls[opX.sgn ? clsNegNorm : clsPosNorm] = 1'b1;
      end
   end

   assign classRes = {{(xLen-10){1'b0}}, cls};

endmodule

//--- source/fpuCore.sv
// Three stage FPU top
`timescale 1ns/100ps

module fpuCore (
   input  logic                    clk,
   input  logic                    rstN,
   input  logic [31:0]             instrD,
   input  logic [fpuPkg::xLen-1:0] intSrcE,      // integer operand of the E instruction
   output logic                    illegalInstrD,
   output logic                    intWriteW,
   output logic [fpuPkg::xLen-1:0] intResW,
   output fpuPkg::fflagsT          setFflagsW
);
   import fpuPkg::*;

   fpuCtrlT               ctrlD, ctrlE, ctrlW;
   logic [regAdrBits-1:0] adr1E, adr2E;
   logic [fLen-1:0]       rd1D, rd2D, rd1E, rd2E;
   logic [fLen-1:0]       srcX, srcY;                 // after forwarding
   logic [fLen-1:0]       minMaxRes, sgnRes, mvFromX, fResE, fResW;
   logic [xLen-1:0]       cmpRes, classRes, mvToX, intResE;
   logic [2:0]            cmpOp;
   logic                  cmpInvalid, usesCmp;
   fflagsT                flagsE;

   fpOperandIf opX ();
   fpOperandIf opY ();

   ////////////////////////////////////////////////////////////////////////////
   // decode
   ////////////////////////////////////////////////////////////////////////////
   fpuDecode decode_i (.instr(instrD), .ctrl(ctrlD), .illegal(illegalInstrD));

   fpRegFile regFile_i (
      .clk, .rstN,
      .rAdr1(instrD[19:15]), .rAdr2(instrD[24:20]),
      .rData1(rd1D), .rData2(rd2D),
      .wEn(ctrlW.fRegWrite), .wAdr(ctrlW.rd), .wData(fResW)   // W stage write
   );

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ctrlE <= '0;                       // bubble
         adr1E <= '0;
         adr2E <= '0;
      end else begin
         ctrlE <= ctrlD;
         adr1E <= instrD[19:15];
         adr2E <= instrD[24:20];
      end
   end

   always_ff @(posedge clk) begin
      rd1E <= rd1D;
      rd2E <= rd2D;
   end

   ////////////////////////////////////////////////////////////////////////////
   // execute
   ////////////////////////////////////////////////////////////////////////////
   // W is the only producer ahead of E
   assign srcX = (ctrlW.fRegWrite && ctrlW.rd == adr1E) ? fResW : rd1E;
   assign srcY = (ctrlW.fRegWrite && ctrlW.rd == adr2E) ? fResW : rd2E;

   fpUnpack unpackX_i (.value(srcX), .fmt(ctrlE.fmt), .op(opX));
   fpUnpack unpackY_i (.value(srcY), .fmt(ctrlE.fmt), .op(opY));

   // min/max and fle share funct3 000, bit 2 tells them apart
   assign cmpOp = {ctrlE.resSel == resMinMax && ctrlE.fRegWrite, ctrlE.opSel[1:0]};

   fpCompare compare_i (
      .fmt(ctrlE.fmt), .opSel(cmpOp), .opX(opX), .opY(opY),
      .cmpRes, .minMaxRes, .invalid(cmpInvalid)
   );

   fpSignClass signClass_i (
      .fmt(ctrlE.fmt), .opSel(ctrlE.opSel), .opX(opX), .opY(opY),
      .sgnRes, .classRes
   );

   // moves are bit-exact, no boxing check on the way out
   assign mvToX   = (ctrlE.fmt == fmtD) ? srcX : {{32{srcX[31]}}, srcX[31:0]};
   assign mvFromX = (ctrlE.fmt == fmtD) ? intSrcE : {32'hFFFF_FFFF, intSrcE[31:0]};

   always_comb begin
      case (ctrlE.resSel)
         resMinMax:  fResE = minMaxRes;
         resMvFromX: fResE = mvFromX;
         default:    fResE = sgnRes;
      endcase
      case (ctrlE.intSel)
         intMvToX: intResE = mvToX;
         intClass: intResE = classRes;
         default:  intResE = cmpRes;
      endcase
   end

   // only compares and min/max raise nv, bubbles raise nothing
   assign usesCmp = (ctrlE.intWrite && ctrlE.intSel == intCmp) ||
                    (ctrlE.fRegWrite && ctrlE.resSel == resMinMax);

   always_comb begin
      flagsE    = '0;
      flagsE.nv = usesCmp & cmpInvalid;
   end

   ////////////////////////////////////////////////////////////////////////////
   // writeback
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         ctrlW      <= '0;
         setFflagsW <= '0;
      end else begin
         ctrlW      <= ctrlE;
         setFflagsW <= flagsE;              // held for one cycle
      end
   end

   always_ff @(posedge clk) begin
      fResW   <= fResE;
      intResW <= intResE;
   end

   assign intWriteW = ctrlW.intWrite;

endmodule

//--- sim/fpuTb.sv
// FPU testbench
`timescale 1ns/100ps

module fpuTb;
   import fpuPkg::*;

   logic        clk;
   logic        rstN;
   logic [31:0] instrD;
   logic [63:0] intSrcE;
   logic        illegalInstrD;
   logic        intWriteW;
   logic [63:0] intResW;
   fflagsT      setFflagsW;
   logic [4:0]  flagsW;

   logic [63:0] fregs [32];           // reference register file
   logic [63:0] pendingSrc;           // integer operand of the instruction now in D
   logic [31:0] lfsr = 32'd1085;
   int          cycle = 0;
   int          postReset;
   int          valErrs = 0;          // wrong values
   int          otherErrs = 0;        // timeouts

   // expected W results, stamped with the issue cycle
   int          qStamp [$];
   logic        qW [$];
   logic [63:0] qR [$];
   logic [4:0]  qF [$];

   localparam logic [31:0] lfsrTaps = 32'h8020_0003;

   fpuCore fpuCore_i (
      .clk, .rstN, .instrD, .intSrcE,
      .illegalInstrD, .intWriteW, .intResW, .setFflagsW
   );

   assign flagsW = setFflagsW;

   always #2 clk = ~clk;              // 4 ns period

   always @(posedge clk) cycle <= cycle + 1;

   always @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         postReset <= 0;
      end else if (postReset < 2) begin
         postReset <= postReset + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // random source and reference model
   ////////////////////////////////////////////////////////////////////////////
   function automatic logic [63:0] randBits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[62:0], lfsr[0]};     // one step per bit
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsrTaps) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic int pick(input int n);
      return int'(randBits(8) % 64'(n));
   endfunction

   function automatic logic [63:0] randOperand();
      logic        s;
      logic [10:0] e11;
      logic [7:0]  e8;
      logic [51:0] f52;
      logic [22:0] f23;
      int          kind;
      kind = pick(5);
      s    = 1'(randBits(1));
      e11  = 11'(randBits(11));
      e8   = 8'(randBits(8));
      f52  = 52'(randBits(52));
      f23  = 23'(randBits(23));
      if (e11 == 11'h000 || e11 == 11'h7FF) e11 = 11'h3FF;   // keep it normal
      if (e8 == 8'h00 || e8 == 8'hFF) e8 = 8'h7F;
      case (kind)
         0:       return {s, e11, f52};
         1:       return {s, 11'h000, f52 | 52'd1};              // double denormal
         2:       return {32'hFFFF_FFFF, s, e8, f23};
         3:       return {32'hFFFF_FFFF, s, 8'h00, f23 | 23'd1}; // single denormal
         default: return randBits(64);
      endcase
   endfunction

   // a single operand that is not boxed reads as the canonical NaN
   function automatic logic [63:0] unbox(input logic [63:0] v, input logic dbl);
      if (!dbl && v[63:32] != 32'hFFFF_FFFF) return 64'hFFFF_FFFF_7FC0_0000;
      return v;
   endfunction

   function automatic logic sgnOf(input logic [63:0] v, input logic dbl);
      return dbl ? v[63] : v[31];
   endfunction

   function automatic logic [62:0] magOf(input logic [63:0] v, input logic dbl);
      return dbl ? v[62:0] : {32'h0, v[30:0]};
   endfunction

   function automatic logic [51:0] fracOf(input logic [63:0] v, input logic dbl);
      return dbl ? v[51:0] : {v[22:0], 29'h0};
   endfunction

   function automatic logic expOnes(input logic [63:0] v, input logic dbl);
      return dbl ? (&v[62:52]) : (&v[30:23]);
   endfunction

   function automatic logic expZeros(input logic [63:0] v, input logic dbl);
      return dbl ? (v[62:52] == 11'h0) : (v[30:23] == 8'h0);
   endfunction

   function automatic logic nanOf(input logic [63:0] v, input logic dbl);
      return expOnes(v, dbl) && fracOf(v, dbl) != 52'h0;
   endfunction

   function automatic logic sNaNOf(input logic [63:0] v, input logic dbl);
      logic [51:0] f;
      f = fracOf(v, dbl);
      return nanOf(v, dbl) && !f[51];   // quiet bit clear
   endfunction

   // total order, -0 below +0
   function automatic logic orderLt(input logic [63:0] a, b, input logic dbl);
      if (sgnOf(a, dbl) != sgnOf(b, dbl)) return sgnOf(a, dbl);
      if (sgnOf(a, dbl)) return magOf(b, dbl) < magOf(a, dbl);
      return magOf(a, dbl) < magOf(b, dbl);
   endfunction

   function automatic logic cmpRef(input logic [63:0] a, b, input logic dbl,
                                   input logic [2:0] f3);
      logic bothZero, eq, lt;
      bothZero = magOf(a, dbl) == 63'h0 && magOf(b, dbl) == 63'h0;
      eq = bothZero || (sgnOf(a, dbl) == sgnOf(b, dbl) && magOf(a, dbl) == magOf(b, dbl));
      lt = orderLt(a, b, dbl) && !bothZero;
      if (nanOf(a, dbl) || nanOf(b, dbl)) return 1'b0;
      case (f3)
         3'd0:    return lt || eq;       // fle
         3'd1:    return lt;             // flt
         default: return eq;             // feq
      endcase
   endfunction

   function automatic logic [63:0] minMaxRef(input logic [63:0] a, b, input logic dbl,
                                             input logic isMax);
      logic lt;
      lt = orderLt(a, b, dbl);
      if (nanOf(a, dbl) && nanOf(b, dbl)) return dbl ? canonNaND : canonNaNS;
      if (nanOf(a, dbl)) return b;
      if (nanOf(b, dbl)) return a;
      if (isMax) return lt ? b : a;
      return lt ? a : b;
   endfunction

   function automatic logic [63:0] sgnInjRef(input logic [63:0] a, b, input logic dbl,
                                             input logic [2:0] f3);
      logic s;
      case (f3)
         3'd0:    s = sgnOf(b, dbl);
         3'd1:    s = ~sgnOf(b, dbl);
         default: s = sgnOf(a, dbl) ^ sgnOf(b, dbl);
      endcase
      return dbl ? {s, a[62:0]} : {32'hFFFF_FFFF, s, a[30:0]};
   endfunction

   function automatic logic [63:0] classRef(input logic [63:0] a, input logic dbl);
      logic [63:0] r;
      logic        s;
      int          idx;
      r = '0;
      s = sgnOf(a, dbl);
      if (sNaNOf(a, dbl))                          idx = 8;
      else if (nanOf(a, dbl))                      idx = 9;
      else if (expOnes(a, dbl))                    idx = s ? 0 : 7;   // inf
      else if (magOf(a, dbl) == 63'h0)             idx = s ? 3 : 4;   // zero
      else if (expZeros(a, dbl))                   idx = s ? 2 : 5;   // subnormal
      else                                         idx = s ? 1 : 6;
      r[idx] = 1'b1;
      return r;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // drivers
   ////////////////////////////////////////////////////////////////////////////
   task automatic driveInstr(input logic [31:0] instr, input logic [63:0] xSrc,
                             input logic expIll, input logic pushIt, input logic eW,
                             input logic [63:0] eR, input logic [4:0] eF);
      @(posedge clk);
      #1;
      instrD     = instr;
      intSrcE    = pendingSrc;         // belongs to the instruction entering E
      pendingSrc = xSrc;
      if (pushIt) begin
         qStamp.push_back(cycle);
         qW.push_back(eW);
         qR.push_back(eR);
         qF.push_back(eF);
      end
      #0.5;
      assert (illegalInstrD === expIll) else begin
         valErrs++;
         $display("Fail illegalInstrD: got %h expected %h", illegalInstrD, expIll);
      end
   endtask

   task automatic idle();
      driveInstr(32'h0, 64'h0, 1'b1, 1'b0, 1'b0, 64'h0, 5'h0);
   endtask

   task automatic issueIllegal(input logic [31:0] instr);
      driveInstr(instr, 64'h0, 1'b1, 1'b1, 1'b0, 64'h0, 5'h0);   // bubble in W
   endtask

   // issue a legal FP instruction and predict its W result
   task automatic issueOp(input logic [4:0] f5, input logic dbl, input logic [2:0] f3,
                          input logic [4:0] rd, rs1, rs2, input logic [63:0] xSrc);
      logic [31:0] instr;
      logic [63:0] a, b, eR;
      logic [4:0]  eF;
      logic        eW;
      instr = {f5, 1'b0, dbl, rs2, rs1, f3, rd, opFp};
      a  = unbox(fregs[rs1], dbl);
      b  = unbox(fregs[rs2], dbl);
      eW = 1'b0;
      eR = 64'h0;
      eF = 5'h0;
      case (f5)
         funct7SgnInj: fregs[rd] = sgnInjRef(a, b, dbl, f3);
         funct7MinMax: begin
            fregs[rd] = minMaxRef(a, b, dbl, f3[0]);
            eF[4]     = sNaNOf(a, dbl) || sNaNOf(b, dbl);
         end
         funct7Cmp: begin
            eW    = 1'b1;
            eR    = {63'h0, cmpRef(a, b, dbl, f3)};
            eF[4] = (f3 == 3'd2) ? (sNaNOf(a, dbl) || sNaNOf(b, dbl)) :
                                   (nanOf(a, dbl) || nanOf(b, dbl));
         end
         funct7ClassMvX: begin
            eW = 1'b1;
            if (f3[0]) eR = classRef(a, dbl);
            else eR = dbl ? fregs[rs1] : {{32{fregs[rs1][31]}}, fregs[rs1][31:0]};
         end
         default: fregs[rd] = dbl ? xSrc : {32'hFFFF_FFFF, xSrc[31:0]};   // fmv from x
      endcase
      driveInstr(instr, xSrc, 1'b0, 1'b1, eW, eR, eF);
   endtask

   task automatic readBack(input logic [4:0] r);
      issueOp(funct7ClassMvX, 1'b1, 3'd0, 5'd0, r, 5'd0, 64'h0);   // fmv.x.d
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // W stage checks
   ////////////////////////////////////////////////////////////////////////////
   always @(negedge clk) begin : checkW
      logic        eW;
      logic [63:0] eR;
      logic [4:0]  eF;
      if (!rstN || postReset < 2) begin
         assert (intWriteW === 1'b0) else begin
            valErrs++;
            $display("Fail intWriteW in reset: got %h expected %h", intWriteW, 1'b0);
         end
         assert (flagsW === 5'h0) else begin
            valErrs++;
            $display("Fail setFflagsW in reset: got %h expected %h", flagsW, 5'h0);
         end
      end
      if (qStamp.size() > 0 && qStamp[0] == cycle - 2) begin
         eW = qW.pop_front();
         eR = qR.pop_front();
         eF = qF.pop_front();
         void'(qStamp.pop_front());
         assert (intWriteW === eW) else begin
            valErrs++;
            $display("Fail intWriteW: got %h expected %h", intWriteW, eW);
         end
         if (eW) begin
            assert (intResW === eR) else begin
               valErrs++;
               $display("Fail intResW: got %h expected %h", intResW, eR);
            end
         end
         assert (flagsW === eF) else begin
            valErrs++;
            $display("Fail setFflagsW: got %h expected %h", flagsW, eF);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////
   initial begin
      logic [63:0] specials [20];
      logic [63:0] v;
      logic [4:0]  rs1, rs2, rd;
      logic        dbl;
      int          n;
      specials = '{
         64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h7FF0_0000_0000_0000,
         64'hFFF0_0000_0000_0000, 64'h7FF8_0000_0000_0000, 64'h7FF0_0000_0000_0001,
         64'h3FF0_0000_0000_0000, 64'hC000_0000_0000_0000, 64'h0000_0000_0000_0001,
         64'h800F_FFFF_FFFF_FFFF,
         64'hFFFF_FFFF_0000_0000, 64'hFFFF_FFFF_8000_0000, 64'hFFFF_FFFF_7F80_0000,
         64'hFFFF_FFFF_FF80_0000, 64'hFFFF_FFFF_7FC0_0000, 64'hFFFF_FFFF_7F80_0001,
         64'hFFFF_FFFF_3F80_0000, 64'hFFFF_FFFF_807F_FFFF, 64'hFFFF_FFFF_C040_0000,
         64'h1234_5678_3F80_0000                       // badly boxed single
      };
      clk        = 1'b0;
      rstN       = 1'b0;
      instrD     = 32'h0;
      intSrcE    = 64'h0;
      pendingSrc = 64'h0;
      for (int i = 0; i < 32; i++) fregs[i] = 64'h0;
      repeat (16) @(posedge clk);
      #1 rstN = 1'b1;

      // moves, forwarding and bypass
      v = randBits(64);
      issueOp(funct7MvFromX, 1'b1, 3'd0, 5'd1, 5'd0, 5'd0, v);
      readBack(5'd1);                                // back-to-back
      issueOp(funct7MvFromX, 1'b1, 3'd0, 5'd2, 5'd0, 5'd0, randBits(64));
      idle();
      readBack(5'd2);                                // two apart
      issueOp(funct7MvFromX, 1'b0, 3'd0, 5'd3, 5'd0, 5'd0, randBits(64) | 64'h8000_0000);
      issueOp(funct7ClassMvX, 1'b0, 3'd0, 5'd0, 5'd3, 5'd0, 64'h0);   // fmv.x.w
      issueOp(funct7MvFromX, 1'b0, 3'd0, 5'd3, 5'd0, 5'd0, 64'h1234_5678_1234_5678);
      issueOp(funct7ClassMvX, 1'b0, 3'd0, 5'd0, 5'd3, 5'd0, 64'h0);

      for (int i = 0; i < 20; i++) begin
         issueOp(funct7MvFromX, 1'b1, 3'd0, 5'(i + 8), 5'd0, 5'd0, specials[i]);
      end
      // bad boxing reads as the canonical NaN
      issueOp(funct7ClassMvX, 1'b0, 3'd1, 5'd0, 5'd27, 5'd0, 64'h0);
      issueOp(funct7SgnInj, 1'b0, 3'd0, 5'd5, 5'd27, 5'd27, 64'h0);
      readBack(5'd5);

      // classify every special in both formats
      for (int r = 8; r < 28; r++) begin
         issueOp(funct7ClassMvX, 1'b1, 3'd1, 5'd0, 5'(r), 5'd0, 64'h0);
         issueOp(funct7ClassMvX, 1'b0, 3'd1, 5'd0, 5'(r), 5'd0, 64'h0);
      end

      // all special pairs within a format
      for (int i = 0; i < 10; i++) begin
         for (int j = 0; j < 10; j++) begin
            for (int k = 0; k < 2; k++) begin
               dbl = (k == 0);
               rs1 = 5'(dbl ? i + 8 : i + 18);
               rs2 = 5'(dbl ? j + 8 : j + 18);
               for (int f = 0; f < 3; f++) begin
                  issueOp(funct7Cmp, dbl, 3'(f), 5'd0, rs1, rs2, 64'h0);
               end
               issueOp(funct7MinMax, dbl, 3'(i % 2), 5'd6, rs1, rs2, 64'h0);
               readBack(5'd6);
               issueOp(funct7SgnInj, dbl, 3'(j % 3), 5'd7, rs1, rs2, 64'h0);
               readBack(5'd7);
            end
         end
      end

      // random mix over specials and fresh values
      for (int it = 0; it < 400; it++) begin
         dbl = 1'(randBits(1));
         rs1 = 5'(pick(27) + 1);
         rs2 = 5'(pick(27) + 1);
         rd  = 5'(pick(7) + 1);
         case (pick(8))
            0: begin
               issueOp(funct7SgnInj, dbl, 3'(pick(3)), rd, rs1, rs2, 64'h0);
               readBack(rd);
            end
            1: begin
               issueOp(funct7MinMax, dbl, 3'(pick(2)), rd, rs1, rs2, 64'h0);
               readBack(rd);
            end
            2: issueOp(funct7Cmp, dbl, 3'(pick(3)), 5'd0, rs1, rs2, 64'h0);
            3: issueOp(funct7ClassMvX, dbl, 3'd1, 5'd0, rs1, 5'd0, 64'h0);
            4: issueOp(funct7ClassMvX, dbl, 3'd0, 5'd0, rs1, 5'd0, 64'h0);
            5: issueOp(funct7MvFromX, 1'b1, 3'd0, rd, 5'd0, 5'd0, randOperand());
            6: issueOp(funct7MvFromX, 1'b0, 3'd0, rd, 5'd0, 5'd0, randBits(64));
            default: idle();
         endcase
      end

      // illegal encodings leave nothing in W
      issueIllegal(32'h0000_0013);                         // addi
      issueIllegal({5'b00000, 2'b01, 5'd2, 5'd1, 3'd0, 5'd3, opFp});   // fadd.d
      issueIllegal({funct7SgnInj, 2'b10, 5'd2, 5'd1, 3'd0, 5'd3, opFp}); // half format
      issueIllegal({funct7SgnInj, 2'b01, 5'd2, 5'd1, 3'd3, 5'd3, opFp});
      issueIllegal({funct7ClassMvX, 2'b01, 5'd1, 5'd1, 3'd1, 5'd3, opFp});
      issueIllegal({funct7MvFromX, 2'b00, 5'd0, 5'd1, 3'd1, 5'd3, opFp});
      readBack(5'd3);                                    // f3 untouched by the above

      // let the pipe drain
      n = 0;
      while (qStamp.size() > 0 && n < 20) begin
         idle();
         n++;
      end
      if (qStamp.size() > 0) begin
         otherErrs++;
         $display("timeout: expected results never left the W stage");
         $display("errors: %0d wrong values, %0d other", valErrs, otherErrs);
         $display("RESULT: FAIL");
         $finish;
      end else begin
         $display("errors: %0d wrong values, %0d other", valErrs, otherErrs);
         if (valErrs == 0 && otherErrs == 0) begin
            $display("RESULT: PASS");
         end else begin
            $display("RESULT: FAIL");
         end
         $finish;
      end
   end

endmodule

//--- all.f
source/fpuPkg.sv
source/fpOperandIf.sv
source/fpuDecode.sv
source/fpRegFile.sv
source/fpUnpack.sv
source/fpCompare.sv
source/fpSignClass.sv
source/fpuCore.sv
sim/fpuTb.sv

//--- run.sh
#!/bin/sh
# build and run the FPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module fpuTb \
   -f all.f \
   -o fpuSim

out=$(./obj_dir/fpuSim)
echo "$out"

# the run counts as passed only when the pass line shows up
echo "$out" | grep -q "^RESULT: PASS$"
